/* source/fetch_pkg.sv */
// fetch front end package with datapath widths, pc constants and configuration map

package fetch_pkg;

  // program counter and instruction word widths
  localparam int PC_WD   = 32;
  localparam int INST_WD = 32;

  // instruction SRAM port, byte addressed, one word per access
  localparam int SRAM_ADDR_WD = 32;
  localparam int SRAM_DATA_WD = 32;

  // sequential step is one 32-bit word
  localparam logic [PC_WD-1:0] PC_STEP = PC_WD'(4);

  // boot vector used until the host writes a new one
  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h8000_0000;

  // configuration port address width
  localparam int CFG_ADDR_WD = 2;

  // boot vector register, full PC_WD bits
  localparam logic [CFG_ADDR_WD-1:0] CFG_BOOT_ADDR = CFG_ADDR_WD'(0);

  // run register, only bit 0 is implemented
  localparam logic [CFG_ADDR_WD-1:0] CFG_RUN_ADDR = CFG_ADDR_WD'(1);

endpackage

/* source/fetch_cfg.sv */
// fetch configuration block with boot vector and run bit behind a four-phase req/ack port

`timescale 1ns/10ps

module fetch_cfg import fetch_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_cfg_req,
  input  logic                   i_cfg_we,
  input  logic [CFG_ADDR_WD-1:0] i_cfg_addr,
  input  logic [PC_WD-1:0]       i_cfg_wdata,
  output logic                   o_cfg_ack,
  output logic [PC_WD-1:0]       o_cfg_rdata,
  output logic [PC_WD-1:0]       o_boot_pc,
  output logic                   o_run,
  output logic                   o_restart
);

  logic             ack_q;
  logic             run_q;
  logic             restart_q;
  logic [PC_WD-1:0] boot_q;
  logic [PC_WD-1:0] rdata_q;
  logic             cfg_start;

  // a request is served once, on the first edge that sees req with ack still low
  assign cfg_start = i_cfg_req && !ack_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ack_q <= 1'b0;
    end else if (cfg_start) begin
      ack_q <= 1'b1;
    end else if (!i_cfg_req) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      boot_q    <= PC_RESETVAL;
      run_q     <= 1'b0;
      restart_q <= 1'b0;
    end else begin
      restart_q <= 1'b0;
      if (cfg_start && i_cfg_we) begin
        if (i_cfg_addr == CFG_BOOT_ADDR) begin
          boot_q <= i_cfg_wdata;
        end
        if (i_cfg_addr == CFG_RUN_ADDR) begin
          run_q <= i_cfg_wdata[0];
          // fetch restarts from the boot vector only on a 0 to 1 edge of run
          restart_q <= i_cfg_wdata[0] && !run_q;
        end
      end
    end
  end

  // read data is captured on the same edge that raises ack
  always_ff @(posedge i_clk) begin
    if (cfg_start && !i_cfg_we) begin
      case (i_cfg_addr)
        CFG_BOOT_ADDR: rdata_q <= boot_q;
        CFG_RUN_ADDR:  rdata_q <= {{(PC_WD-1){1'b0}}, run_q};
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign o_cfg_ack   = ack_q;
  assign o_cfg_rdata = rdata_q;
  assign o_boot_pc   = boot_q;
  assign o_run       = run_q;
  assign o_restart   = restart_q;

  // the host holds the request fields until it has seen ack
  a_req_stable : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_cfg_req && !o_cfg_ack) |=> $stable({i_cfg_we, i_cfg_addr, i_cfg_wdata}));

endmodule

/* source/fetch_pc.sv */
// fetch program counter with sequential step, branch redirect and restart to the boot vector

`timescale 1ns/10ps

module fetch_pc import fetch_pkg::*; (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_load,
  input  logic             i_restart,
  input  logic [PC_WD-1:0] i_boot_pc,
  input  logic             i_br_taken,
  input  logic [PC_WD-1:0] i_br_target,
  output logic [PC_WD-1:0] o_pc,
  output logic [PC_WD-1:0] o_next_pc
);

  logic [PC_WD-1:0] pc_q;
  logic [PC_WD-1:0] next_pc;

  // restart wins over a branch in the same cycle, the old stream is dead either way
  always_comb begin
    if (i_restart) begin
      next_pc = i_boot_pc;
    end else if (i_br_taken) begin
      next_pc = i_br_target;
    end else begin
      next_pc = pc_q + PC_STEP;
    end
  end

  // pc_q is the address of the word now coming back from the SRAM
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= PC_RESETVAL;
    end else if (i_load || i_restart) begin
      pc_q <= next_pc;
    end
  end

  assign o_pc      = pc_q;
  assign o_next_pc = next_pc;

endmodule

/* source/fetch_ifu.sv */
// instruction fetch unit that addresses the instruction SRAM and returns the fetched word

`timescale 1ns/10ps

module fetch_ifu import fetch_pkg::*; (
  input  logic                    i_req,
  input  logic [PC_WD-1:0]        i_next_pc,
  output logic [INST_WD-1:0]      o_inst,
  output logic                    o_inst_sram_en,
  output logic [SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0] i_inst_sram_rdata
);

  logic [SRAM_ADDR_WD-1:0] word_addr;

  // the SRAM is word wide, so the two byte offset bits never reach it
  assign word_addr = {i_next_pc[SRAM_ADDR_WD-1:2], 2'b00};

  assign o_inst_sram_en   = i_req;
  assign o_inst_sram_addr = word_addr;

  // rdata belongs to the pc requested one cycle earlier, the SRAM holds it while idle
  assign o_inst = INST_WD'(i_inst_sram_rdata);

  // boot vector and branch targets must be word aligned, otherwise the
  // masked address would fetch a different word than the pc says
  always_comb begin
    if (o_inst_sram_en) begin
      a_addr_aligned : assert (o_inst_sram_addr == SRAM_ADDR_WD'(i_next_pc));
    end
  end

endmodule

/* source/fetch_stage.sv */
// fetch stage with one-slot valid and allowin control, presenting instruction and pc to decode

`timescale 1ns/10ps

module fetch_stage import fetch_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_run,
  input  logic                     i_restart,
  input  logic [PC_WD-1:0]         i_boot_pc,
  input  logic                     i_br_taken,
  input  logic [PC_WD-1:0]         i_br_target,
  input  logic                     i_ds_allowin,
  output logic                     o_fs_to_ds_valid,
  output logic [INST_WD+PC_WD-1:0] o_fs_to_ds_bus,
  output logic                     o_inst_sram_en,
  output logic [SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0]  i_inst_sram_rdata
);

  logic               fs_valid_q;
  logic               fs_kill;
  logic               fs_allowin;
  logic               fs_req;
  logic [PC_WD-1:0]   fs_pc;
  logic [PC_WD-1:0]   fs_next_pc;
  logic [INST_WD-1:0] fs_inst;

  // a branch or a restart throws away whatever sits in the slot
  assign fs_kill = i_br_taken || i_restart;

  // the killed item is never offered to decode
  assign o_fs_to_ds_valid = fs_valid_q && !fs_kill;

  // slot is free when empty, when its item leaves this cycle, or when it is killed
  assign fs_allowin = !fs_valid_q || (o_fs_to_ds_valid && i_ds_allowin) || fs_kill;

  // a restart fetches the boot vector even though the slot logic alone would not ask
  assign fs_req = (i_run && fs_allowin) || i_restart;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fs_valid_q <= 1'b0;
    end else if (fs_allowin) begin
      fs_valid_q <= fs_req;
    end
  end

  fetch_pc u_pc (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_load      (fs_req),
    .i_restart   (i_restart),
    .i_boot_pc   (i_boot_pc),
    .i_br_taken  (i_br_taken),
    .i_br_target (i_br_target),
    .o_pc        (fs_pc),
    .o_next_pc   (fs_next_pc)
  );

  fetch_ifu u_ifu (
    .i_req             (fs_req),
    .i_next_pc         (fs_next_pc),
    .o_inst            (fs_inst),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  assign o_fs_to_ds_bus = {fs_inst, fs_pc};

  // a stalled item relies on both the pc register and the SRAM output holding
  a_bus_stable_on_stall : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_fs_to_ds_valid && !i_ds_allowin) |=> $stable(o_fs_to_ds_bus));

endmodule

/* source/fetch_top.sv */
// fetch front end top level joining the configuration block and the fetch stage

`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_cfg_req,
  input  logic                     i_cfg_we,
  input  logic [CFG_ADDR_WD-1:0]   i_cfg_addr,
  input  logic [PC_WD-1:0]         i_cfg_wdata,
  output logic                     o_cfg_ack,
  output logic [PC_WD-1:0]         o_cfg_rdata,
  input  logic                     i_br_taken,
  input  logic [PC_WD-1:0]         i_br_target,
  input  logic                     i_ds_allowin,
  output logic                     o_fs_to_ds_valid,
  output logic [INST_WD+PC_WD-1:0] o_fs_to_ds_bus,
  output logic                     o_inst_sram_en,
  output logic [SRAM_ADDR_WD-1:0]  o_inst_sram_addr,
  input  logic [SRAM_DATA_WD-1:0]  i_inst_sram_rdata
);

  logic [PC_WD-1:0] cfg_boot_pc;
  logic             cfg_run;
  logic             cfg_restart;

  fetch_cfg u_cfg (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_cfg_req   (i_cfg_req),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .o_cfg_ack   (o_cfg_ack),
    .o_cfg_rdata (o_cfg_rdata),
    .o_boot_pc   (cfg_boot_pc),
    .o_run       (cfg_run),
    .o_restart   (cfg_restart)
  );

  fetch_stage u_fs (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_run             (cfg_run),
    .i_restart         (cfg_restart),
    .i_boot_pc         (cfg_boot_pc),
    .i_br_taken        (i_br_taken),
    .i_br_target       (i_br_target),
    .i_ds_allowin      (i_ds_allowin),
    .o_fs_to_ds_valid  (o_fs_to_ds_valid),
    .o_fs_to_ds_bus    (o_fs_to_ds_bus),
    .o_inst_sram_en    (o_inst_sram_en),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

endmodule

/* dv/fetch_inst_mem.sv */
// instruction SRAM model with one-cycle read latency that holds its output while idle

`timescale 1ns/10ps

module fetch_inst_mem import fetch_pkg::*; #(
  parameter int IDX_WD = 10
) (
  input  logic                    i_clk,
  input  logic                    i_en,
  input  logic [SRAM_ADDR_WD-1:0] i_addr,
  output logic [SRAM_DATA_WD-1:0] o_rdata
);

  // contents are written by the testbench before fetch starts
  logic [SRAM_DATA_WD-1:0] mem [2**IDX_WD];
  logic [IDX_WD-1:0]       idx;

  // only the word index selects a location, the byte offset bits are ignored
  assign idx = i_addr[IDX_WD+1:2];

  // the stored word is mixed with the full address so aliased locations still differ
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= mem[idx] ^ SRAM_DATA_WD'(i_addr);
    end
  end

endmodule

/* dv/fetch_tb.sv */
// fetch front end testbench with configuration driver, decode sink and pc/instruction model

`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DLY     = 10;
  localparam int RESET_CYCLES  = 5;
  localparam int MEM_IDX_WD    = 10;
  localparam int MEM_WORDS     = 2**MEM_IDX_WD;
  localparam int CFG_WAIT_MAX  = 8;
  localparam int CFG_CYCLES    = 96;
  localparam int SEQ_ITEMS     = 200;
  localparam int STALL_ITEMS   = 300;
  localparam int BRANCH_ITEMS  = 300;
  localparam int QUIET_CYCLES  = 20;
  localparam int RESTART_ITEMS = 100;
  // stalled and branching tests need a few cycles per accepted item
  localparam int TEST_CYCLES   = RESET_CYCLES + CFG_CYCLES + SEQ_ITEMS + 2 * STALL_ITEMS +
                                 3 * BRANCH_ITEMS + 2 * QUIET_CYCLES + 3 * RESTART_ITEMS;
  localparam int WATCHDOG_NS   = TEST_CYCLES * 4 * CLK_PERIOD;

  logic                     clk;
  logic                     arst_n;
  logic                     cfg_req;
  logic                     cfg_we;
  logic [CFG_ADDR_WD-1:0]   cfg_addr;
  logic [PC_WD-1:0]         cfg_wdata;
  logic                     cfg_ack;
  logic [PC_WD-1:0]         cfg_rdata;
  logic                     br_taken;
  logic [PC_WD-1:0]         br_target;
  logic                     ds_allowin;
  logic                     fs_valid;
  logic [INST_WD+PC_WD-1:0] fs_bus;
  logic                     sram_en;
  logic [SRAM_ADDR_WD-1:0]  sram_addr;
  logic [SRAM_DATA_WD-1:0]  sram_rdata;

  // reference model state
  logic [SRAM_DATA_WD-1:0]  model_mem [MEM_WORDS];
  logic [PC_WD-1:0]         exp_pc;
  int                       accept_cnt;
  bit                       stall_en;
  bit                       br_en;

  fetch_top i_dut (
    .i_clk (clk), .i_arst_n (arst_n),
    .i_cfg_req (cfg_req), .i_cfg_we (cfg_we), .i_cfg_addr (cfg_addr),
    .i_cfg_wdata (cfg_wdata), .o_cfg_ack (cfg_ack), .o_cfg_rdata (cfg_rdata),
    .i_br_taken (br_taken), .i_br_target (br_target), .i_ds_allowin (ds_allowin),
    .o_fs_to_ds_valid (fs_valid), .o_fs_to_ds_bus (fs_bus),
    .o_inst_sram_en (sram_en), .o_inst_sram_addr (sram_addr),
    .i_inst_sram_rdata (sram_rdata)
  );

  fetch_inst_mem #(.IDX_WD (MEM_IDX_WD)) u_mem (
    .i_clk (clk), .i_en (sram_en), .i_addr (sram_addr), .o_rdata (sram_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("STATUS: FAIL");
    $fatal(1, "simulation timeout");
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // expected word of the memory model at a byte address
  function automatic logic [SRAM_DATA_WD-1:0] word_at(input logic [PC_WD-1:0] pc);
    return model_mem[pc[MEM_IDX_WD+1:2]] ^ pc;
  endfunction

  // one four-phase transfer, ack must follow each req edge after exactly one clock
  task automatic cfg_access(input logic we, input logic [CFG_ADDR_WD-1:0] addr,
                            input logic [PC_WD-1:0] wdata, output logic [PC_WD-1:0] rdata);
    int waited;
    @(posedge clk);
    #DRIVE_DLY;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    cfg_req   = 1'b1;
    @(negedge clk);
    check_value("cfg_ack_early", 64'd0, 64'(cfg_ack));
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!cfg_ack && waited < CFG_WAIT_MAX);
    check_value("cfg_ack_rise_cycles", 64'd1, 64'(waited));
    rdata = cfg_rdata;
    @(posedge clk);
    #DRIVE_DLY;
    cfg_req = 1'b0;
    @(negedge clk);
    check_value("cfg_ack_held", 64'd1, 64'(cfg_ack));
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (cfg_ack && waited < CFG_WAIT_MAX);
    check_value("cfg_ack_fall_cycles", 64'd1, 64'(waited));
  endtask

  task automatic drive_decode_sink;
    ds_allowin = 1'b0;
    br_taken   = 1'b0;
    br_target  = '0;
    forever begin
      @(posedge clk);
      #DRIVE_DLY;
      ds_allowin = stall_en ? ($urandom_range(1, 0) == 1) : 1'b1;
      br_taken   = br_en && ($urandom_range(7, 0) == 0);
      br_target  = PC_WD'($urandom()) & ~PC_WD'(3);
    end
  endtask

  // samples at the falling edge, where the transfer of the next rising edge is decided
  task automatic monitor_decode;
    logic                     prev_stall;
    logic [INST_WD+PC_WD-1:0] held_bus;
    logic [PC_WD-1:0]         pc;
    logic [INST_WD-1:0]       inst;
    prev_stall = 1'b0;
    held_bus   = '0;
    forever begin
      @(negedge clk);
      pc   = fs_bus[PC_WD-1:0];
      inst = fs_bus[INST_WD+PC_WD-1:PC_WD];
      if (arst_n) begin
        if (br_taken) begin
          check_value("branch_cycle_valid", 64'd0, 64'(fs_valid));
          exp_pc = br_target;
        end
        if (prev_stall && fs_valid) begin
          check_value("stall_bus_hold", 64'(held_bus), 64'(fs_bus));
        end
        if (fs_valid && ds_allowin) begin
          check_value("accept_pc", 64'(exp_pc), 64'(pc));
          check_value("accept_inst", 64'(word_at(exp_pc)), 64'(inst));
          exp_pc = exp_pc + PC_STEP;
          accept_cnt++;
        end
        prev_stall = fs_valid && !ds_allowin;
        held_bus   = fs_bus;
      end
    end
  endtask

  task automatic wait_accepts(input int n);
    int target;
    target = accept_cnt + n;
    while (accept_cnt < target) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [PC_WD-1:0] rd;
    logic [PC_WD-1:0] boot;
    arst_n     = 1'b0;
    cfg_req    = 1'b0;
    cfg_we     = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    stall_en   = 1'b0;
    br_en      = 1'b0;
    accept_cnt = 0;
    exp_pc     = PC_RESETVAL;
    void'($urandom(32'h00eb6a21));
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i]  = $urandom();
      u_mem.mem[i]  = model_mem[i];
    end
    fork
      drive_decode_sink();
      monitor_decode();
    join_none
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    @(negedge clk);
    check_value("reset_valid", 64'd0, 64'(fs_valid));
    check_value("reset_ack", 64'd0, 64'(cfg_ack));
    check_value("reset_sram_en", 64'd0, 64'(sram_en));

    // configuration write and read-back
    cfg_access(1'b0, CFG_BOOT_ADDR, '0, rd);
    check_value("cfg_reset_boot", 64'(PC_RESETVAL), 64'(rd));
    boot = PC_WD'($urandom()) & ~PC_WD'(3);
    cfg_access(1'b1, CFG_BOOT_ADDR, boot, rd);
    cfg_access(1'b0, CFG_BOOT_ADDR, '0, rd);
    check_value("cfg_boot_readback", 64'(boot), 64'(rd));
    cfg_access(1'b0, CFG_RUN_ADDR, '0, rd);
    check_value("cfg_run_reset", 64'd0, 64'(rd));
    cfg_access(1'b0, CFG_ADDR_WD'(2), '0, rd);
    check_value("cfg_unmapped_read", 64'd0, 64'(rd));
    exp_pc = boot;
    cfg_access(1'b1, CFG_RUN_ADDR, PC_WD'(1), rd);
    cfg_access(1'b0, CFG_RUN_ADDR, '0, rd);
    check_value("cfg_run_readback", 64'd1, 64'(rd));

    // sequential stream, then back-pressure, then branches on top
    wait_accepts(SEQ_ITEMS);
    stall_en = 1'b1;
    wait_accepts(STALL_ITEMS);
    br_en = 1'b1;
    wait_accepts(BRANCH_ITEMS);

    // clear run, let the held item drain and check that fetch stays idle
    br_en = 1'b0;
    cfg_access(1'b1, CFG_RUN_ADDR, '0, rd);
    stall_en = 1'b0;
    repeat (2) @(negedge clk);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      check_value("run_clear_valid", 64'd0, 64'(fs_valid));
      check_value("run_clear_sram_en", 64'd0, 64'(sram_en));
    end
    boot = PC_WD'($urandom()) & ~PC_WD'(3);
    cfg_access(1'b1, CFG_BOOT_ADDR, boot, rd);
    exp_pc = boot;
    cfg_access(1'b1, CFG_RUN_ADDR, PC_WD'(1), rd);
    stall_en = 1'b1;
    br_en    = 1'b1;
    wait_accepts(RESTART_ITEMS);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* vlog.f */
source/fetch_pkg.sv
source/fetch_cfg.sv
source/fetch_pc.sv
source/fetch_ifu.sv
source/fetch_stage.sv
source/fetch_top.sv
dv/fetch_inst_mem.sv
dv/fetch_tb.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module fetch_tb -f vlog.f \
		-Mdir $(OBJ_DIR) -o fetch_sim

run: build
	./$(OBJ_DIR)/fetch_sim

lint:
	verilator --lint-only -Wall --top-module fetch_top \
		source/fetch_pkg.sv source/fetch_cfg.sv source/fetch_pc.sv \
		source/fetch_ifu.sv source/fetch_stage.sv source/fetch_top.sv

clean:
	rm -rf $(OBJ_DIR)
